// File: axi_lite_master.f
rtl/axi_lite_pkg.sv
rtl/addr_align_check.sv
rtl/beat_sequencer.sv
rtl/write_lane_packer.sv
rtl/read_capture.sv
rtl/axi_lite_master.sv
verif/axi_lite_master_sva.sv
verif/axi_lite_master_tb.sv

// File: rtl/addr_align_check.sv
module addr_align_check (
    input  logic [31:0] addr,
    input  logic [1:0]  size,
    output logic        aligned,
    output logic [3:0]  strb
);

    logic [1:0] lane;

    assign lane = addr[1:0];   // Low address bits pick the byte lane

    always_comb begin
        case (size)
            2'd0: begin
                aligned = 1'b1;                  // Any byte lane works
                strb    = 4'b0001 << lane;
            end
            2'd1: begin
                aligned = ~lane[0];
                strb    = 4'b0011 << lane;
            end
            2'd2: begin
                // Word must sit on lane 0
                aligned = (lane == 2'b00);
                strb    = 4'b1111;
            end
            default: begin
                aligned = 1'b0;                  // Reserved size code
                strb    = 4'b0000;
            end
        endcase
    end

endmodule

// File: rtl/axi_lite_master.sv
module axi_lite_master #(
    parameter int AXI_TIMEOUT = 2500
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  axi_lite_pkg::cmd_t                      cmd,
    input  logic [31:0]                             addr,
    input  logic [axi_lite_pkg::BUF_BYTES-1:0][7:0] write_data,
    input  logic                                    start,
    output logic                                    done,
    output axi_lite_pkg::status_t                   status,
    output logic [axi_lite_pkg::BUF_BYTES-1:0][7:0] read_data,
    output logic [axi_lite_pkg::IDX_W-1:0]          read_count,
    output axi_lite_pkg::addr_chan_t                aw,
    output logic                                    aw_valid,
    input  logic                                    aw_ready,
    output axi_lite_pkg::wdata_chan_t               w,
    output logic                                    w_valid,
    input  logic                                    w_ready,
    input  logic [1:0]                              b_resp,
    input  logic                                    b_valid,
    output logic                                    b_ready,
    output axi_lite_pkg::addr_chan_t                ar,
    output logic                                    ar_valid,
    input  logic                                    ar_ready,
    input  logic [31:0]                             r_data,
    input  logic [1:0]                              r_resp,
    input  logic                                    r_valid,
    output logic                                    r_ready
);

    axi_lite_pkg::cmd_t             cur_cmd;
    logic [31:0]                    cur_addr;
    logic [axi_lite_pkg::IDX_W-1:0] byte_idx;
    logic                           aligned;
    logic [3:0]                     strb;
    logic                           last_beat;
    logic                           r_take;

    // Same address on both channels, plain data access
    assign aw     = '{addr: cur_addr, prot: 3'b000};
    assign ar     = '{addr: cur_addr, prot: 3'b000};
    assign r_take = r_valid & r_ready;

    addr_align_check u_align (
        .addr    (cur_addr),
        .size    (cur_cmd.size),
        .aligned (aligned),
        .strb    (strb)
    );

    beat_sequencer #(
        .AXI_TIMEOUT (AXI_TIMEOUT)
    ) u_seq (
        .clk          (clk),
        .rst          (rst),
        .cmd          (cmd),
        .addr         (addr),
        .start        (start),
        .aligned      (aligned),
        .aw_ready     (aw_ready),
        .w_ready      (w_ready),
        .b_valid      (b_valid),
        .b_resp       (b_resp),
        .ar_ready     (ar_ready),
        .r_valid      (r_valid),
        .r_resp       (r_resp),
        .cur_cmd      (cur_cmd),
        .cur_addr     (cur_addr),
        .byte_idx     (byte_idx),
        .aw_valid     (aw_valid),
        .w_valid      (w_valid),
        .b_ready      (b_ready),
        .ar_valid     (ar_valid),
        .r_valid_take (r_ready),
        .last_beat    (last_beat),
        .done         (done),
        .status       (status)
    );

    write_lane_packer u_pack (
        .write_data (write_data),
        .byte_idx   (byte_idx),
        .addr_lo    (cur_addr[1:0]),
        .strb       (strb),
        .w          (w)
    );

    read_capture u_cap (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .r_take     (r_take),
        .r_data     (r_data),
        .size       (cur_cmd.size),
        .addr_lo    (cur_addr[1:0]),
        .byte_idx   (byte_idx),
        .last_beat  (last_beat),
        .read_data  (read_data),
        .read_count (read_count)
    );

endmodule

// File: rtl/axi_lite_pkg.sv
package axi_lite_pkg;

    // Buffer geometry
    localparam int BUF_BYTES = 64;
    localparam int IDX_W = 7;                    // Byte index and count, 0..64
    localparam int BUF_AW = $clog2(BUF_BYTES);   // Slot select inside the buffer

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Status byte returned with done
    typedef enum logic [7:0] {
        STATUS_OK         = 8'h00,
        STATUS_ADDR_ALIGN = 8'h03,
        STATUS_TIMEOUT    = 8'h04,
        STATUS_SLVERR     = 8'h05
    } status_t;

    // Command byte, rw in the top bit
    typedef struct packed {
        logic       rw;     // 1 = read
        logic       inc;    // Step address after each beat
        logic [1:0] size;   // 0 byte, 1 half, 2 word
        logic [3:0] len;    // Beats minus one
    } cmd_t;

    // AW and AR share one layout
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  prot;
    } addr_chan_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } wdata_chan_t;

    typedef enum logic [3:0] {
        IDLE      = 4'h0,
        CHECK     = 4'h1,
        WR_ADDR   = 4'h2,
        WR_DATA   = 4'h3,
        WR_RESP   = 4'h4,
        RD_ADDR   = 4'h5,
        RD_DATA   = 4'h6,
        NEXT_BEAT = 4'h7,
        DONE      = 4'h8,
        ERROR     = 4'h9
    } seq_state_t;

    // Bytes moved per beat for a size code
    function automatic logic [IDX_W-1:0] beat_bytes(input logic [1:0] size);
        case (size)
            2'd0:    return IDX_W'(1);
            2'd1:    return IDX_W'(2);
            2'd2:    return IDX_W'(4);
            default: return '0;      // Size 3 never reaches the bus
        endcase
    endfunction

endpackage

// File: rtl/beat_sequencer.sv
module beat_sequencer #(
    parameter int AXI_TIMEOUT = 2500
) (
    input  logic                            clk,
    input  logic                            rst,
    input  axi_lite_pkg::cmd_t              cmd,
    input  logic [31:0]                     addr,
    input  logic                            start,
    input  logic                            aligned,
    input  logic                            aw_ready,
    input  logic                            w_ready,
    input  logic                            b_valid,
    input  logic [1:0]                      b_resp,
    input  logic                            ar_ready,
    input  logic                            r_valid,
    input  logic [1:0]                      r_resp,
    output axi_lite_pkg::cmd_t              cur_cmd,
    output logic [31:0]                     cur_addr,
    output logic [axi_lite_pkg::IDX_W-1:0]  byte_idx,
    output logic                            aw_valid,
    output logic                            w_valid,
    output logic                            b_ready,
    output logic                            ar_valid,
    output logic                            r_valid_take,
    output logic                            last_beat,
    output logic                            done,
    output axi_lite_pkg::status_t           status
);

    localparam int TMO_W = $clog2(AXI_TIMEOUT + 1);

    axi_lite_pkg::seq_state_t state;
    axi_lite_pkg::seq_state_t state_nxt;

    logic [3:0]                     beat_cnt;
    logic [TMO_W-1:0]               tmo_cnt;
    logic [axi_lite_pkg::IDX_W-1:0] step;
    logic                           accept;
    logic                           waiting;
    logic                           timed_out;
    logic                           aw_hs, w_hs, b_hs, ar_hs, r_hs;
    logic                           any_hs;

    // One strobe per wait state
    assign aw_valid     = (state == axi_lite_pkg::WR_ADDR);
    assign w_valid      = (state == axi_lite_pkg::WR_DATA);
    assign b_ready      = (state == axi_lite_pkg::WR_RESP);
    assign ar_valid     = (state == axi_lite_pkg::RD_ADDR);
    assign r_valid_take = (state == axi_lite_pkg::RD_DATA);

    assign aw_hs  = aw_valid & aw_ready;
    assign w_hs   = w_valid & w_ready;
    assign b_hs   = b_ready & b_valid;
    assign ar_hs  = ar_valid & ar_ready;
    assign r_hs   = r_valid_take & r_valid;
    assign any_hs = aw_hs | w_hs | b_hs | ar_hs | r_hs;

    assign accept    = (state == axi_lite_pkg::IDLE) && start;
    assign waiting   = aw_valid | w_valid | b_ready | ar_valid | r_valid_take;
    assign timed_out = waiting && (tmo_cnt == TMO_W'(AXI_TIMEOUT));
    assign last_beat = (beat_cnt == cur_cmd.len);
    assign step      = axi_lite_pkg::beat_bytes(cur_cmd.size);

    always_comb begin
        state_nxt = state;
        case (state)
            axi_lite_pkg::IDLE: begin
                if (start) state_nxt = axi_lite_pkg::CHECK;
            end
            axi_lite_pkg::CHECK: begin
                if (!aligned)        state_nxt = axi_lite_pkg::ERROR;
                else if (cur_cmd.rw) state_nxt = axi_lite_pkg::RD_ADDR;
                else                 state_nxt = axi_lite_pkg::WR_ADDR;
            end
            axi_lite_pkg::WR_ADDR: begin
                if (aw_hs)          state_nxt = axi_lite_pkg::WR_DATA;
                else if (timed_out) state_nxt = axi_lite_pkg::ERROR;
            end
            axi_lite_pkg::WR_DATA: begin
                if (w_hs)           state_nxt = axi_lite_pkg::WR_RESP;
                else if (timed_out) state_nxt = axi_lite_pkg::ERROR;
            end
            axi_lite_pkg::WR_RESP: begin
                if (b_hs) begin
                    state_nxt = last_beat ? axi_lite_pkg::DONE : axi_lite_pkg::NEXT_BEAT;
                end else if (timed_out) begin
                    state_nxt = axi_lite_pkg::ERROR;
                end
            end
            axi_lite_pkg::RD_ADDR: begin
                if (ar_hs)          state_nxt = axi_lite_pkg::RD_DATA;
                else if (timed_out) state_nxt = axi_lite_pkg::ERROR;
            end
            axi_lite_pkg::RD_DATA: begin
                if (r_hs) begin
                    state_nxt = last_beat ? axi_lite_pkg::DONE : axi_lite_pkg::NEXT_BEAT;
                end else if (timed_out) begin
                    state_nxt = axi_lite_pkg::ERROR;
                end
            end
            axi_lite_pkg::NEXT_BEAT: begin
                state_nxt = cur_cmd.rw ? axi_lite_pkg::RD_ADDR : axi_lite_pkg::WR_ADDR;
            end
            default: state_nxt = axi_lite_pkg::IDLE;   // DONE and ERROR return here
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= axi_lite_pkg::IDLE;
            beat_cnt <= '0;
            byte_idx <= '0;
            tmo_cnt  <= '0;
            done     <= 1'b0;
            status   <= axi_lite_pkg::STATUS_OK;
        end else begin
            state <= state_nxt;
            // Pulse in the cycle after DONE or ERROR
            done  <= (state == axi_lite_pkg::DONE) || (state == axi_lite_pkg::ERROR);

            // Counts one wait at a time, restarts on every handshake
            if (waiting && !any_hs && !timed_out) tmo_cnt <= tmo_cnt + 1'b1;
            else                                   tmo_cnt <= '0;

            if (accept) begin
                beat_cnt <= '0;
                byte_idx <= '0;
                status   <= axi_lite_pkg::STATUS_OK;
            end

            if (state == axi_lite_pkg::NEXT_BEAT) begin
                beat_cnt <= beat_cnt + 4'd1;
                byte_idx <= byte_idx + step;    // Buffer always advances
            end

            if ((state == axi_lite_pkg::CHECK) && !aligned) begin
                status <= axi_lite_pkg::STATUS_ADDR_ALIGN;
            end
            if (waiting && (state_nxt == axi_lite_pkg::ERROR)) begin
                status <= axi_lite_pkg::STATUS_TIMEOUT;
            end
            // Error response is recorded but the beats carry on
            if ((b_hs && (b_resp != axi_lite_pkg::RESP_OKAY)) ||
                (r_hs && (r_resp != axi_lite_pkg::RESP_OKAY))) begin
                status <= axi_lite_pkg::STATUS_SLVERR;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cur_cmd  <= cmd;
            cur_addr <= addr;
        end else if ((state == axi_lite_pkg::NEXT_BEAT) && cur_cmd.inc) begin
            cur_addr <= cur_addr + 32'(step);
        end
    end

endmodule

// File: rtl/read_capture.sv
module read_capture (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    start,
    input  logic                                    r_take,
    input  logic [31:0]                             r_data,
    input  logic [1:0]                              size,
    input  logic [1:0]                              addr_lo,
    input  logic [axi_lite_pkg::IDX_W-1:0]          byte_idx,
    input  logic                                    last_beat,
    output logic [axi_lite_pkg::BUF_BYTES-1:0][7:0] read_data,
    output logic [axi_lite_pkg::IDX_W-1:0]          read_count
);

    localparam int SLOT_W = axi_lite_pkg::BUF_AW;

    logic [axi_lite_pkg::IDX_W-1:0] bsize;
    logic [3:0][7:0]                r_lanes;
    logic [3:0][7:0]                beat_byte;
    logic [3:0][SLOT_W-1:0]         slot;
    logic [3:0]                     wr_en;

    assign bsize   = axi_lite_pkg::beat_bytes(size);
    assign r_lanes = r_data;

    // Beat byte j comes from lane addr_lo + j
    for (genvar j = 0; j < 4; j++) begin : g_byte
        logic [1:0] lane;

        assign lane         = addr_lo + 2'(j);
        assign beat_byte[j] = r_lanes[lane];
        assign slot[j]      = byte_idx[SLOT_W-1:0] + SLOT_W'(j);
        assign wr_en[j]     = r_take && (j < int'(bsize));
    end

    // Buffer holds its contents between commands
    always_ff @(posedge clk) begin
        for (int j = 0; j < 4; j++) begin
            if (wr_en[j]) read_data[slot[j]] <= beat_byte[j];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            read_count <= '0;
        end else if (start) begin
            read_count <= '0;
        end else if (r_take && last_beat) begin
            read_count <= byte_idx + bsize;     // Index of last beat plus its size
        end
    end

endmodule

// File: rtl/write_lane_packer.sv
module write_lane_packer (
    input  logic [axi_lite_pkg::BUF_BYTES-1:0][7:0] write_data,
    input  logic [axi_lite_pkg::IDX_W-1:0]          byte_idx,
    input  logic [1:0]                              addr_lo,
    input  logic [3:0]                              strb,
    output axi_lite_pkg::wdata_chan_t               w
);

    localparam int SLOT_W = axi_lite_pkg::BUF_AW;

    logic [3:0][7:0]        lanes;
    logic [SLOT_W-1:0]      base;

    // Buffer slot that lands on lane 0, wraps below the start lane
    assign base = byte_idx[SLOT_W-1:0] - SLOT_W'(addr_lo);

    for (genvar k = 0; k < 4; k++) begin : g_lane
        logic [SLOT_W-1:0] slot;

        assign slot     = base + SLOT_W'(k);
        assign lanes[k] = strb[k] ? write_data[slot] : 8'h00;   // Idle lanes stay zero
    end

    assign w = '{data: lanes, strb: strb};

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module axi_lite_master_tb \
    -f axi_lite_master.f \
    -o axi_lite_master_sim

out=$(./obj_dir/axi_lite_master_sim)
echo "$out"
grep -qx "Regression passed" <<< "$out"

// File: verif/axi_lite_master_sva.sv
module axi_lite_master_sva (
    input logic                           clk,
    input logic                           rst,
    input axi_lite_pkg::seq_state_t       state,
    input logic                           aw_valid,
    input logic                           aw_ready,
    input logic                           w_valid,
    input logic                           w_ready,
    input logic                           ar_valid,
    input logic                           ar_ready,
    input logic                           b_ready,
    input logic                           r_valid_take,
    input logic                           done,
    input logic [axi_lite_pkg::IDX_W-1:0] byte_idx
);

    // Valid stays up until taken, unless the wait times out
    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid || state == axi_lite_pkg::ERROR)
        else $error("AW valid dropped before it was accepted");
    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        w_valid && !w_ready |=> w_valid || state == axi_lite_pkg::ERROR)
        else $error("W valid dropped before it was accepted");
    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid || state == axi_lite_pkg::ERROR)
        else $error("AR valid dropped before it was accepted");

    a_one_chan: assert property (@(posedge clk) disable iff (rst)
        $onehot0({aw_valid, w_valid, b_ready, ar_valid, r_valid_take}))
        else $error("More than one channel strobe active");

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done held longer than one cycle");

    a_idx_range: assert property (@(posedge clk) disable iff (rst)
        byte_idx <= axi_lite_pkg::IDX_W'(axi_lite_pkg::BUF_BYTES))
        else $error("Byte index ran past the buffer");

endmodule

bind beat_sequencer axi_lite_master_sva u_sva (.*);

// File: verif/axi_lite_master_tb.sv
module axi_lite_master_tb;

    localparam int AXI_TIMEOUT = 40;
    localparam int N_ENTRIES   = 18;
    localparam int LIMIT_CYC   = N_ENTRIES * 16 * (AXI_TIMEOUT + 8);

    typedef struct packed {
        axi_lite_pkg::cmd_t    cmd;
        logic [31:0]           addr;
        logic [7:0]            seed;    // Write buffer pattern
        axi_lite_pkg::status_t st;
        logic [6:0]            count;   // Expected read_count
    } entry_t;

    logic                             clk = 1'b0;
    logic                             rst = 1'b1;
    axi_lite_pkg::cmd_t               cmd = '0;
    logic [31:0]                      addr = '0;
    logic [63:0][7:0]                 write_data = '0;
    logic                             start = 1'b0;
    logic                             done;
    axi_lite_pkg::status_t            status;
    logic [63:0][7:0]                 read_data;
    logic [axi_lite_pkg::IDX_W-1:0]   read_count;
    axi_lite_pkg::addr_chan_t         aw;
    axi_lite_pkg::addr_chan_t         ar;
    axi_lite_pkg::wdata_chan_t        w;
    logic                             aw_valid, w_valid, b_ready, ar_valid, r_ready;
    logic                             aw_ready = 1'b0;
    logic                             w_ready = 1'b0;
    logic                             b_valid = 1'b0;
    logic [1:0]                       b_resp = 2'b00;
    logic                             ar_ready = 1'b0;
    logic                             r_valid = 1'b0;
    logic [1:0]                       r_resp = 2'b00;
    logic [31:0]                      r_data = '0;

    logic [7:0]  mem [256];       // Byte addressed slave memory of 64 words
    logic [7:0]  shadow [256];
    logic [31:0] rng = 32'd57387;
    logic [31:0] wr_addr = '0;
    logic [31:0] rd_addr = '0;
    int          aw_wait, w_wait, b_wait, ar_wait, r_wait;
    int          errors, checks, cycles;
    entry_t      tbl [N_ENTRIES];

    axi_lite_master #(.AXI_TIMEOUT(AXI_TIMEOUT)) UUT (.*);

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [7:0] mem_fill(input logic [7:0] a);
        return (a * 8'd13) ^ 8'h5a;     // Power-on contents of the slave memory
    endfunction

    function automatic logic [1:0] slave_resp(input logic [31:0] a);
        return (a[31:4] == 28'h010) ? 2'b10 : 2'b00;
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] a);
        int base;
        base = int'({a[7:2], 2'b00});
        if (a >= 32'h100) return '0;
        return {mem[base + 3], mem[base + 2], mem[base + 1], mem[base]};
    endfunction

    function automatic entry_t make_entry(input int rw, input int inc, input int size,
                                          input int len, input int a, input int seed,
                                          input axi_lite_pkg::status_t st, input int count);
        entry_t e;
        e.cmd   = '{rw: rw[0], inc: inc[0], size: size[1:0], len: len[3:0]};
        e.addr  = a;
        e.seed  = seed[7:0];
        e.st    = st;
        e.count = count[6:0];
        return e;
    endfunction

    // Counts down a random stall and fires at zero with a fresh draw
    task automatic gate_stall(inout int cnt, output bit go);
        go = (cnt == 0);
        if (go) begin
            rng = xorshift(rng);
            cnt = int'(rng[1:0]);
        end else begin
            cnt--;
        end
    endtask

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // Slave model with one-cycle readies and valids
    always @(negedge clk) begin
        bit go;
        if (rst) begin
            for (int i = 0; i < 256; i++) mem[i] = mem_fill(8'(i));
        end else begin
            if (aw_valid) compare(aw.prot, 0, "AW prot");
            if (ar_valid) compare(ar.prot, 0, "AR prot");
            if (aw_ready) aw_ready <= 1'b0;
            else if (aw_valid && aw.addr < 32'h200) begin   // 0x200 and up never answer
                gate_stall(aw_wait, go);
                if (go) begin
                    aw_ready <= 1'b1;
                    wr_addr = aw.addr;
                end
            end
            if (w_ready) w_ready <= 1'b0;
            else if (w_valid) begin
                gate_stall(w_wait, go);
                if (go) begin
                    w_ready <= 1'b1;
                    for (int k = 0; k < 4; k++) begin
                        if (w.strb[k] && wr_addr < 32'h100)
                            mem[int'({wr_addr[7:2], 2'(k)})] = w.data[8*k +: 8];
                    end
                end
            end
            if (b_valid) b_valid <= 1'b0;
            else if (b_ready) begin
                gate_stall(b_wait, go);
                if (go) begin
                    b_valid <= 1'b1;
                    b_resp  <= slave_resp(wr_addr);
                end
            end
            if (ar_ready) ar_ready <= 1'b0;
            else if (ar_valid && ar.addr < 32'h200) begin
                gate_stall(ar_wait, go);
                if (go) begin
                    ar_ready <= 1'b1;
                    rd_addr = ar.addr;
                end
            end
            if (r_valid) r_valid <= 1'b0;
            else if (r_ready) begin
                gate_stall(r_wait, go);
                if (go) begin
                    r_valid <= 1'b1;
                    r_resp  <= slave_resp(rd_addr);
                    r_data  <= word_at(rd_addr);
                end
            end
        end
    end

    task automatic run_entry(input entry_t e);
        int         cyc;
        int         sz;
        int         b;
        int         j;
        int         i;
        bit         saw_bus;
        logic [7:0] a;
        sz = 1 << e.cmd.size;
        for (i = 0; i < 64; i++) write_data[i] = 8'(int'(e.seed) + i * 29);
        cmd   = e.cmd;
        addr  = e.addr;
        start = 1'b1;
        @(negedge clk);
        start   = 1'b0;
        cyc     = 1;
        saw_bus = 1'b0;
        while (!done) begin
            if (aw_valid || w_valid || b_ready || ar_valid || r_ready) saw_bus = 1'b1;
            // Stray start while a write is in flight
            if (cyc == 4 && !e.cmd.rw && e.st == axi_lite_pkg::STATUS_OK) begin
                cmd   = '{rw: 1'b0, inc: 1'b1, size: 2'd2, len: 4'd3};
                addr  = 32'h0F0;
                start = 1'b1;
            end else begin
                start = 1'b0;
            end
            @(negedge clk);
            cyc++;
        end
        start = 1'b0;
        compare(status, e.st, "status");
        compare(read_count, e.count, "read_count");
        if (e.st == axi_lite_pkg::STATUS_ADDR_ALIGN) begin
            compare(cyc, 3, "done latency after start");
            compare(saw_bus, 0, "bus activity on rejected command");
        end
        if (e.st == axi_lite_pkg::STATUS_OK) begin
            for (b = 0; b <= int'(e.cmd.len); b++) begin
                a = 8'(e.addr + (e.cmd.inc ? b * sz : 0));
                for (j = 0; j < sz; j++) begin
                    if (e.cmd.rw) compare(read_data[b*sz + j], shadow[8'(a + j)], "read byte");
                    else shadow[8'(a + j)] = write_data[b*sz + j];
                end
            end
        end
        for (i = 0; i < 256; i++) compare(mem[i], shadow[i], $sformatf("memory byte %0d", i));
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT_CYC) begin
            $display("Run stopped, command table not finished after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        int n;
        // rw, inc, size, len, addr, seed, status, read_count
        tbl[0]  = make_entry(0, 1, 2, 3, 'h000, 'h11, axi_lite_pkg::STATUS_OK, 0);
        tbl[1]  = make_entry(0, 1, 1, 5, 'h012, 'h22, axi_lite_pkg::STATUS_OK, 0);
        tbl[2]  = make_entry(0, 1, 0, 6, 'h021, 'h33, axi_lite_pkg::STATUS_OK, 0);
        tbl[3]  = make_entry(1, 1, 2, 3, 'h000, 'h00, axi_lite_pkg::STATUS_OK, 16);
        tbl[4]  = make_entry(1, 1, 1, 5, 'h012, 'h00, axi_lite_pkg::STATUS_OK, 12);
        tbl[5]  = make_entry(1, 1, 0, 6, 'h021, 'h00, axi_lite_pkg::STATUS_OK, 7);
        tbl[6]  = make_entry(0, 0, 2, 3, 'h040, 'h44, axi_lite_pkg::STATUS_OK, 0);
        tbl[7]  = make_entry(1, 0, 1, 3, 'h042, 'h00, axi_lite_pkg::STATUS_OK, 8);
        tbl[8]  = make_entry(0, 1, 1, 0, 'h031, 'h55, axi_lite_pkg::STATUS_ADDR_ALIGN, 0);
        tbl[9]  = make_entry(1, 1, 2, 2, 'h006, 'h00, axi_lite_pkg::STATUS_ADDR_ALIGN, 0);
        tbl[10] = make_entry(0, 1, 3, 0, 'h000, 'h66, axi_lite_pkg::STATUS_ADDR_ALIGN, 0);
        tbl[11] = make_entry(0, 1, 2, 1, 'h100, 'h77, axi_lite_pkg::STATUS_SLVERR, 0);
        tbl[12] = make_entry(1, 1, 2, 2, 'h104, 'h00, axi_lite_pkg::STATUS_SLVERR, 12);
        tbl[13] = make_entry(0, 1, 2, 0, 'h200, 'h88, axi_lite_pkg::STATUS_TIMEOUT, 0);
        tbl[14] = make_entry(1, 1, 2, 1, 'h050, 'h00, axi_lite_pkg::STATUS_OK, 8);
        tbl[15] = make_entry(1, 1, 2, 0, 'h200, 'h00, axi_lite_pkg::STATUS_TIMEOUT, 0);
        tbl[16] = make_entry(0, 0, 0, 0, 'h0E3, 'h99, axi_lite_pkg::STATUS_OK, 0);
        tbl[17] = make_entry(1, 0, 0, 0, 'h0E3, 'h00, axi_lite_pkg::STATUS_OK, 1);
        for (n = 0; n < 256; n++) shadow[n] = mem_fill(8'(n));
        repeat (2) @(negedge clk);
        rst = 1'b0;
        compare(done, 0, "done after reset");
        compare({aw_valid, w_valid, b_ready, ar_valid, r_ready}, 0, "strobes after reset");
        compare(status, axi_lite_pkg::STATUS_OK, "status after reset");
        compare(read_count, 0, "read_count after reset");
        for (n = 0; n < N_ENTRIES; n++) run_entry(tbl[n]);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) $display("Regression passed");
        else $display("Regression failed");
        $finish;
    end

endmodule
